/* tb.f */
verilog/rx_dp_pkg.sv
verilog/rx_word_align.sv
verilog/rx_flag_stretch.sv
verilog/rx_fifo_buffer.sv
verilog/rx_pld_out.sv
verilog/rx_datapath_top.sv
bench/tb_rx_datapath.sv

/* Makefile */
# Verilator build for the receive datapath testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_datapath
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
SRCS      := $(wildcard verilog/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_rx_datapath.sv */
// Receive datapath directed testbench
`default_nettype none

module tb_rx_datapath import rx_dp_pkg::*; ();

   localparam int CLK_PERIOD = 20;
   localparam int PEMPTY_LVL = 2;    // Partial-empty threshold
   localparam int PFULL_LVL  = 14;   // Partial-full threshold
   localparam int STRETCH    = 3;    // Flag hold cycles
   // Cycle budget per test in run order, reset first
   localparam int TEST_CYC   = 5 + 8 + 14 + 4 + 46 + 10 + 18;
   localparam int WATCHDOG_T = (2 * TEST_CYC + 20) * CLK_PERIOD;

   logic      rx_clock_fifo_sclk = 1'b0;
   logic      rx_reset_fifo_sclk_rst_n;
   rx_word_t  aib_fabric_rx_data_in;
   logic      pld_rx_fabric_fifo_rd_en;
   logic      pld_rx_fabric_fifo_align_clr;
   fifo_cnt_t r_rx_fifo_pempty;
   fifo_cnt_t r_rx_fifo_pfull;
   stretch_t  r_rx_stretch_num_stages;
   logic      r_rx_usertest_sel;
   logic      nfrzdrv_in;
   logic      pr_channel_freeze_n;
   logic      aib_fabric_pld_rx_hssi_fifo_latency_pulse;
   rx_word_t  pld_rx_fabric_data_out;
   logic      pld_rx_fabric_fifo_empty;
   logic      pld_rx_fabric_fifo_pempty;
   logic      pld_rx_fabric_fifo_full;
   logic      pld_rx_fabric_fifo_pfull;
   logic      pld_rx_fabric_fifo_del;
   logic      pld_rx_fabric_fifo_insert;
   logic      pld_rx_fabric_align_done;
   logic      pld_rx_hssi_fifo_latency_pulse;
   logic      wa_error;
   wa_cnt_t   wa_error_cnt;

   integer    seed;
   logic      mark;          // Marker the aligner expects next
   rx_word_t  exp_q [$];     // Reference FIFO contents
   int        err_n;         // Expected alignment error count

   rx_datapath_top u_rx_datapath_top (.*);   // TB names match DUT ports

   always #(CLK_PERIOD / 2) rx_clock_fifo_sclk = ~rx_clock_fifo_sclk;

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic check_word(input string name, input rx_word_t exp, input rx_word_t act);
      if (exp !== act) begin
         $display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
         $display("FAIL: see errors above");
         $fatal(1, "word mismatch");
      end
   endtask

   task automatic check_cnt(input string name, input wa_cnt_t exp, input wa_cnt_t act);
      if (exp !== act) begin
         $display("FAILED time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
         $display("FAIL: see errors above");
         $fatal(1, "count mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("FAILED time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
         $display("FAIL: see errors above");
         $fatal(1, "flag mismatch");
      end
   endtask

   // ------------------------------
   // Drive helpers
   // ------------------------------
   task automatic step();
      @(posedge rx_clock_fifo_sclk);
      #2;                             // Drive point after the edge
   endtask

   function automatic logic [37:0] rand_payload();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return r[37:0];
   endfunction

   // One-cycle valid word whose marker toggles when good is set
   task automatic send_word(input logic [37:0] payload, input logic good, output rx_word_t w);
      w = '0;
      w[MARKER_BIT] = good ? mark : ~mark;   // Bad word repeats last marker
      w[VALID_BIT]  = 1'b1;
      w[37:0]       = payload;
      aib_fabric_rx_data_in = w;
      if (good) begin
         mark = ~mark;
      end
      step();
      aib_fabric_rx_data_in = '0;
   endtask

   task automatic read_word(output rx_word_t got);
      pld_rx_fabric_fifo_rd_en = 1'b1;
      step();
      pld_rx_fabric_fifo_rd_en = 1'b0;
      got = pld_rx_fabric_data_out;    // One cycle after rd_en
   endtask

   // Empty and pempty against the model level
   task automatic check_level_flags();
      check_flag("pld_rx_fabric_fifo_empty", exp_q.size() == 0, pld_rx_fabric_fifo_empty);
      check_flag("pld_rx_fabric_fifo_pempty", exp_q.size() <= PEMPTY_LVL,
                 pld_rx_fabric_fifo_pempty);
   endtask

   task automatic check_frozen();
      check_word("pld_rx_fabric_data_out", '1, pld_rx_fabric_data_out);
      check_flag("pld_rx_fabric_fifo_empty", 1'b1, pld_rx_fabric_fifo_empty);
      check_flag("pld_rx_fabric_fifo_pempty", 1'b1, pld_rx_fabric_fifo_pempty);
      check_flag("pld_rx_fabric_fifo_full", 1'b1, pld_rx_fabric_fifo_full);
      check_flag("pld_rx_fabric_fifo_pfull", 1'b1, pld_rx_fabric_fifo_pfull);
      check_flag("pld_rx_fabric_fifo_del", 1'b1, pld_rx_fabric_fifo_del);
      check_flag("pld_rx_fabric_fifo_insert", 1'b1, pld_rx_fabric_fifo_insert);
      check_flag("pld_rx_fabric_align_done", 1'b1, pld_rx_fabric_align_done);
      check_flag("pld_rx_hssi_fifo_latency_pulse", 1'b1, pld_rx_hssi_fifo_latency_pulse);
   endtask

   // ------------------------------
   // Tests
   // ------------------------------
   task automatic test_lock();
      rx_word_t w;
      check_level_flags();
      for (int i = 0; i < WA_LOCK_CNT + 1; i++) begin
         check_flag("pld_rx_fabric_align_done", 1'b0, pld_rx_fabric_align_done);
         send_word(rand_payload(), 1'b1, w);
      end
      check_flag("pld_rx_fabric_align_done", 1'b1, pld_rx_fabric_align_done);
      check_level_flags();              // Lock-making word not stored
   endtask

   task automatic test_order();
      rx_word_t w;
      for (int i = 0; i < 6; i++) begin
         send_word(rand_payload(), 1'b1, w);
         exp_q.push_back(w);
         check_level_flags();
      end
      for (int i = 0; i < 6; i++) begin
         read_word(w);
         check_word("pld_rx_fabric_data_out", exp_q.pop_front(), w);
         check_flag("pld_rx_fabric_fifo_insert", 1'b0, pld_rx_fabric_fifo_insert);
         check_level_flags();
      end
   endtask

   task automatic test_insert();
      rx_word_t w;
      read_word(w);                     // FIFO is empty here
      check_word("pld_rx_fabric_data_out", IDLE_WORD, w);
      check_flag("pld_rx_fabric_fifo_insert", 1'b1, pld_rx_fabric_fifo_insert);
      step();
      check_flag("pld_rx_fabric_fifo_insert", 1'b0, pld_rx_fabric_fifo_insert);
      check_word("pld_rx_fabric_data_out", IDLE_WORD, pld_rx_fabric_data_out);
   endtask

   task automatic test_full();
      rx_word_t w;
      for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
         send_word(rand_payload(), 1'b1, w);
         if (exp_q.size() < FIFO_DEPTH) begin
            exp_q.push_back(w);
         end
         check_flag("pld_rx_fabric_fifo_full", exp_q.size() == FIFO_DEPTH,
                    pld_rx_fabric_fifo_full);
         check_flag("pld_rx_fabric_fifo_pfull", exp_q.size() >= PFULL_LVL,
                    pld_rx_fabric_fifo_pfull);
         check_flag("pld_rx_fabric_fifo_del", i >= FIFO_DEPTH, pld_rx_fabric_fifo_del);
      end
      // Del held STRETCH cycles past the last drop
      for (int i = 1; i < STRETCH; i++) begin
         step();
         check_flag("pld_rx_fabric_fifo_del", 1'b1, pld_rx_fabric_fifo_del);
      end
      step();
      check_flag("pld_rx_fabric_fifo_del", 1'b0, pld_rx_fabric_fifo_del);
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         read_word(w);
         check_word("pld_rx_fabric_data_out", exp_q.pop_front(), w);
      end
      check_level_flags();
      for (int i = 0; i < 3; i++) begin  // Refill a little, then flush
         send_word(rand_payload(), 1'b1, w);
         exp_q.push_back(w);
      end
      check_level_flags();
      pld_rx_fabric_fifo_align_clr = 1'b1;
      step();
      pld_rx_fabric_fifo_align_clr = 1'b0;
      exp_q.delete();
      check_level_flags();
   endtask

   task automatic test_align_err();
      rx_word_t w;
      send_word(rand_payload(), 1'b0, w);
      err_n++;
      check_flag("wa_error", 1'b1, wa_error);
      check_cnt("wa_error_cnt", wa_cnt_t'(err_n), wa_error_cnt);
      check_level_flags();              // Bad word dropped
      step();
      check_flag("wa_error", 1'b0, wa_error);
      check_flag("pld_rx_fabric_align_done", 1'b1, pld_rx_fabric_align_done);
      send_word(rand_payload(), 1'b1, w);   // Clears the loss count
      exp_q.push_back(w);
      for (int i = 0; i < WA_LOSS_CNT; i++) begin
         check_flag("pld_rx_fabric_align_done", 1'b1, pld_rx_fabric_align_done);
         send_word(rand_payload(), 1'b0, w);
         err_n++;
         check_flag("wa_error", 1'b1, wa_error);
         check_cnt("wa_error_cnt", wa_cnt_t'(err_n), wa_error_cnt);
      end
      check_flag("pld_rx_fabric_align_done", 1'b0, pld_rx_fabric_align_done);
      read_word(w);
      check_word("pld_rx_fabric_data_out", exp_q.pop_front(), w);
      check_level_flags();
   endtask

   task automatic test_freeze();
      rx_word_t w;
      // Relock and store three words so empty and pempty sit low
      for (int i = 0; i < WA_LOCK_CNT + 4; i++) begin
         send_word(rand_payload(), 1'b1, w);
         if (i > WA_LOCK_CNT) begin
            exp_q.push_back(w);
         end
      end
      // Then drop lock so align_done sits low too
      for (int i = 0; i < WA_LOSS_CNT; i++) begin
         send_word(rand_payload(), 1'b0, w);
         err_n++;
      end
      check_level_flags();
      check_flag("pld_rx_fabric_align_done", 1'b0, pld_rx_fabric_align_done);
      nfrzdrv_in = 1'b0;
      #1 check_frozen();
      nfrzdrv_in          = 1'b1;
      pr_channel_freeze_n = 1'b0;
      #1 check_frozen();
      pr_channel_freeze_n = 1'b1;
      step();
      // Pass-through path
      r_rx_usertest_sel = 1'b0;
      aib_fabric_pld_rx_hssi_fifo_latency_pulse = 1'b1;
      #1 check_flag("pld_rx_hssi_fifo_latency_pulse", 1'b1, pld_rx_hssi_fifo_latency_pulse);
      step();
      aib_fabric_pld_rx_hssi_fifo_latency_pulse = 1'b0;
      #1 check_flag("pld_rx_hssi_fifo_latency_pulse", 1'b0, pld_rx_hssi_fifo_latency_pulse);
      step();                           // Register back to low
      // Registered path, one cycle late
      r_rx_usertest_sel = 1'b1;
      aib_fabric_pld_rx_hssi_fifo_latency_pulse = 1'b1;
      #1 check_flag("pld_rx_hssi_fifo_latency_pulse", 1'b0, pld_rx_hssi_fifo_latency_pulse);
      step();
      aib_fabric_pld_rx_hssi_fifo_latency_pulse = 1'b0;
      #1 check_flag("pld_rx_hssi_fifo_latency_pulse", 1'b1, pld_rx_hssi_fifo_latency_pulse);
      step();
      #1 check_flag("pld_rx_hssi_fifo_latency_pulse", 1'b0, pld_rx_hssi_fifo_latency_pulse);
   endtask

   // ------------------------------
   // Main sequence and watchdog
   // ------------------------------
   initial begin
      seed  = 32'h5e83_30d9;
      mark  = 1'b0;
      err_n = 0;
      rx_reset_fifo_sclk_rst_n     = 1'b0;
      aib_fabric_rx_data_in        = '0;
      pld_rx_fabric_fifo_rd_en     = 1'b0;
      pld_rx_fabric_fifo_align_clr = 1'b0;
      r_rx_fifo_pempty             = fifo_cnt_t'(PEMPTY_LVL);
      r_rx_fifo_pfull              = fifo_cnt_t'(PFULL_LVL);
      r_rx_stretch_num_stages      = stretch_t'(STRETCH);
      r_rx_usertest_sel            = 1'b0;
      nfrzdrv_in                   = 1'b1;   // Freeze released
      pr_channel_freeze_n          = 1'b1;
      aib_fabric_pld_rx_hssi_fifo_latency_pulse = 1'b0;
      repeat (4) @(posedge rx_clock_fifo_sclk);
      #2 rx_reset_fifo_sclk_rst_n = 1'b1;
      test_lock();
      test_order();
      test_insert();
      test_full();
      test_align_err();
      test_freeze();
      $display("PASS: all tests");
      $finish;
   end

   initial begin
      #(WATCHDOG_T);
      $display("Timeout: tests did not finish in the allowed time");
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

/* verilog/rx_datapath_top.sv */
// Receive datapath top level
`default_nettype none

module rx_datapath_top import rx_dp_pkg::*; (
   input  logic      rx_clock_fifo_sclk,
   input  logic      rx_reset_fifo_sclk_rst_n,
   input  rx_word_t  aib_fabric_rx_data_in,
   input  logic      pld_rx_fabric_fifo_rd_en,
   input  logic      pld_rx_fabric_fifo_align_clr,
   input  fifo_cnt_t r_rx_fifo_pempty,
   input  fifo_cnt_t r_rx_fifo_pfull,
   input  stretch_t  r_rx_stretch_num_stages,
   input  logic      r_rx_usertest_sel,
   input  logic      nfrzdrv_in,
   input  logic      pr_channel_freeze_n,
   input  logic      aib_fabric_pld_rx_hssi_fifo_latency_pulse,
   output rx_word_t  pld_rx_fabric_data_out,
   output logic      pld_rx_fabric_fifo_empty,
   output logic      pld_rx_fabric_fifo_pempty,
   output logic      pld_rx_fabric_fifo_full,
   output logic      pld_rx_fabric_fifo_pfull,
   output logic      pld_rx_fabric_fifo_del,
   output logic      pld_rx_fabric_fifo_insert,
   output logic      pld_rx_fabric_align_done,
   output logic      pld_rx_hssi_fifo_latency_pulse,
   output logic      wa_error,       // To status reg
   output wa_cnt_t   wa_error_cnt    // To status reg
);

   logic     wa_lock;
   logic     wa_word_ok;
   rx_word_t rd_data;
   logic     fifo_insert;
   logic     fifo_empty;
   logic     fifo_pempty;
   logic     wr_full_raw;
   logic     wr_pfull_raw;
   logic     fifo_del_raw;
   logic     full_stretch;
   logic     pfull_stretch;
   logic     del_stretch;

   // ------------------------------
   // Aligner and FIFO
   // ------------------------------
   rx_word_align u_rx_word_align (
      .rx_clock_fifo_sclk       (rx_clock_fifo_sclk),
      .rx_reset_fifo_sclk_rst_n (rx_reset_fifo_sclk_rst_n),
      .aib_fabric_rx_data_in    (aib_fabric_rx_data_in),
      .wa_lock                  (wa_lock),
      .wa_word_ok               (wa_word_ok),
      .wa_error                 (wa_error),
      .wa_error_cnt             (wa_error_cnt)
   );

   rx_fifo_buffer u_rx_fifo_buffer (
      .rx_clock_fifo_sclk       (rx_clock_fifo_sclk),
      .rx_reset_fifo_sclk_rst_n (rx_reset_fifo_sclk_rst_n),
      .aib_fabric_rx_data_in    (aib_fabric_rx_data_in),
      .wa_word_ok               (wa_word_ok),
      .rd_en                    (pld_rx_fabric_fifo_rd_en),
      .align_clr                (pld_rx_fabric_fifo_align_clr),
      .r_rx_fifo_pempty         (r_rx_fifo_pempty),
      .r_rx_fifo_pfull          (r_rx_fifo_pfull),
      .rd_data                  (rd_data),
      .fifo_insert              (fifo_insert),
      .fifo_empty               (fifo_empty),
      .fifo_pempty              (fifo_pempty),
      .wr_full_raw              (wr_full_raw),
      .wr_pfull_raw             (wr_pfull_raw),
      .fifo_del_raw             (fifo_del_raw)
   );

   // Full, pfull and del held for the fabric
   rx_flag_stretch u_rx_flag_stretch (
      .rx_clock_fifo_sclk       (rx_clock_fifo_sclk),
      .rx_reset_fifo_sclk_rst_n (rx_reset_fifo_sclk_rst_n),
      .r_rx_stretch_num_stages  (r_rx_stretch_num_stages),
      .wr_full_raw              (wr_full_raw),
      .wr_pfull_raw             (wr_pfull_raw),
      .fifo_del_raw             (fifo_del_raw),
      .full_stretch             (full_stretch),
      .pfull_stretch            (pfull_stretch),
      .del_stretch              (del_stretch)
   );

   // ------------------------------
   // Fabric side
   // ------------------------------
   rx_pld_out u_rx_pld_out (
      .rx_clock_fifo_sclk                        (rx_clock_fifo_sclk),
      .rx_reset_fifo_sclk_rst_n                  (rx_reset_fifo_sclk_rst_n),
      .nfrzdrv_in                                (nfrzdrv_in),
      .pr_channel_freeze_n                       (pr_channel_freeze_n),
      .r_rx_usertest_sel                         (r_rx_usertest_sel),
      .aib_fabric_pld_rx_hssi_fifo_latency_pulse (aib_fabric_pld_rx_hssi_fifo_latency_pulse),
      .rd_data                                   (rd_data),
      .fifo_empty                                (fifo_empty),
      .fifo_pempty                               (fifo_pempty),
      .full_stretch                              (full_stretch),
      .pfull_stretch                             (pfull_stretch),
      .del_stretch                               (del_stretch),
      .fifo_insert                               (fifo_insert),
      .wa_lock                                   (wa_lock),
      .pld_rx_fabric_data_out                    (pld_rx_fabric_data_out),
      .pld_rx_fabric_fifo_empty                  (pld_rx_fabric_fifo_empty),
      .pld_rx_fabric_fifo_pempty                 (pld_rx_fabric_fifo_pempty),
      .pld_rx_fabric_fifo_full                   (pld_rx_fabric_fifo_full),
      .pld_rx_fabric_fifo_pfull                  (pld_rx_fabric_fifo_pfull),
      .pld_rx_fabric_fifo_del                    (pld_rx_fabric_fifo_del),
      .pld_rx_fabric_fifo_insert                 (pld_rx_fabric_fifo_insert),
      .pld_rx_fabric_align_done                  (pld_rx_fabric_align_done),
      .pld_rx_hssi_fifo_latency_pulse            (pld_rx_hssi_fifo_latency_pulse)
   );

endmodule

`default_nettype wire

/* verilog/rx_pld_out.sv */
// Fabric output stage with freeze
`default_nettype none

module rx_pld_out import rx_dp_pkg::*; (
   input  logic      rx_clock_fifo_sclk,
   input  logic      rx_reset_fifo_sclk_rst_n,
   input  logic      nfrzdrv_in,          // Freeze, active low
   input  logic      pr_channel_freeze_n, // PR freeze, active low
   input  logic      r_rx_usertest_sel,   // 1 selects registered pulse
   input  logic      aib_fabric_pld_rx_hssi_fifo_latency_pulse,
   input  rx_word_t  rd_data,
   input  logic      fifo_empty,
   input  logic      fifo_pempty,
   input  logic      full_stretch,
   input  logic      pfull_stretch,
   input  logic      del_stretch,
   input  logic      fifo_insert,
   input  logic      wa_lock,
   output rx_word_t  pld_rx_fabric_data_out,
   output logic      pld_rx_fabric_fifo_empty,
   output logic      pld_rx_fabric_fifo_pempty,
   output logic      pld_rx_fabric_fifo_full,
   output logic      pld_rx_fabric_fifo_pfull,
   output logic      pld_rx_fabric_fifo_del,
   output logic      pld_rx_fabric_fifo_insert,
   output logic      pld_rx_fabric_align_done,
   output logic      pld_rx_hssi_fifo_latency_pulse
);

   logic frz_n;          // High when channel is live
   logic lat_pulse_q;    // One cycle late copy
   logic lat_pulse_sel;

   // Latency pulse pipeline
   always_ff @(posedge rx_clock_fifo_sclk) begin
      if (!rx_reset_fifo_sclk_rst_n) begin
         lat_pulse_q <= 1'b0;
      end else begin
         lat_pulse_q <= aib_fabric_pld_rx_hssi_fifo_latency_pulse;
      end
   end

   assign lat_pulse_sel = r_rx_usertest_sel ? lat_pulse_q
                                            : aib_fabric_pld_rx_hssi_fifo_latency_pulse;

   // ------------------------------
   // Freeze drives ones to fabric
   // ------------------------------
   assign frz_n = nfrzdrv_in & pr_channel_freeze_n;

   assign pld_rx_fabric_data_out         = frz_n ? rd_data       : '1;
   assign pld_rx_fabric_fifo_empty       = frz_n ? fifo_empty    : 1'b1;
   assign pld_rx_fabric_fifo_pempty      = frz_n ? fifo_pempty   : 1'b1;
   assign pld_rx_fabric_fifo_full        = frz_n ? full_stretch  : 1'b1;
   assign pld_rx_fabric_fifo_pfull       = frz_n ? pfull_stretch : 1'b1;
   assign pld_rx_fabric_fifo_del         = frz_n ? del_stretch   : 1'b1;
   assign pld_rx_fabric_fifo_insert      = frz_n ? fifo_insert   : 1'b1;
   assign pld_rx_fabric_align_done       = frz_n ? wa_lock       : 1'b1;
   assign pld_rx_hssi_fifo_latency_pulse = frz_n ? lat_pulse_sel : 1'b1;

endmodule

`default_nettype wire

/* verilog/rx_fifo_buffer.sv */
// Receive FIFO with delete and insert
`default_nettype none

module rx_fifo_buffer import rx_dp_pkg::*; (
   input  logic       rx_clock_fifo_sclk,
   input  logic       rx_reset_fifo_sclk_rst_n,
   input  rx_word_t   aib_fabric_rx_data_in,
   input  logic       wa_word_ok,         // Write strobe from aligner
   input  logic       rd_en,              // Fabric read strobe
   input  logic       align_clr,          // Flush
   input  fifo_cnt_t  r_rx_fifo_pempty,   // Partial-empty threshold
   input  fifo_cnt_t  r_rx_fifo_pfull,    // Partial-full threshold
   output rx_word_t   rd_data,
   output logic       fifo_insert,        // Idle word delivered
   output logic       fifo_empty,
   output logic       fifo_pempty,
   output logic       wr_full_raw,
   output logic       wr_pfull_raw,
   output logic       fifo_del_raw        // Word dropped on full
);

   rx_word_t   mem [FIFO_DEPTH];
   fifo_addr_t wr_ptr;
   fifo_addr_t rd_ptr;
   fifo_cnt_t  level;     // Fill level, 0 to FIFO_DEPTH
   logic       wr_push;
   logic       rd_pop;
   logic       rd_ins;    // Read of an empty FIFO

   // ------------------------------
   // Flags off registered level
   // ------------------------------
   assign fifo_empty   = (level == '0);
   assign wr_full_raw  = (level == fifo_cnt_t'(FIFO_DEPTH));
   assign fifo_pempty  = (level <= r_rx_fifo_pempty);
   assign wr_pfull_raw = (level >= r_rx_fifo_pfull);

   // Flush beats both ports
   assign wr_push      = wa_word_ok & ~wr_full_raw & ~align_clr;
   assign fifo_del_raw = wa_word_ok &  wr_full_raw & ~align_clr;
   assign rd_pop       = rd_en & ~fifo_empty & ~align_clr;
   assign rd_ins       = rd_en &  fifo_empty & ~align_clr;

   // Storage
   always_ff @(posedge rx_clock_fifo_sclk) begin
      if (wr_push) begin
         mem[wr_ptr] <= aib_fabric_rx_data_in;
      end
   end

   // ------------------------------
   // Pointers, level, read port
   // ------------------------------
   always_ff @(posedge rx_clock_fifo_sclk) begin
      if (!rx_reset_fifo_sclk_rst_n) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         level       <= '0;
         rd_data     <= IDLE_WORD;
         fifo_insert <= 1'b0;
      end else begin
         fifo_insert <= rd_ins;   // Lines up with the idle word
         if (align_clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
         end else begin
            if (wr_push) begin
               wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            end
            if (rd_pop) begin
               rd_ptr <= rd_ptr + 1'b1;
            end
            level <= level + fifo_cnt_t'(wr_push) - fifo_cnt_t'(rd_pop);
         end
         if (rd_pop) begin
            rd_data <= mem[rd_ptr];     // Head word, held until next read
         end else if (rd_ins) begin
            rd_data <= IDLE_WORD;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/rx_flag_stretch.sv */
// FIFO flag pulse stretcher
`default_nettype none

module rx_flag_stretch import rx_dp_pkg::*; (
   input  logic      rx_clock_fifo_sclk,
   input  logic      rx_reset_fifo_sclk_rst_n,
   input  stretch_t  r_rx_stretch_num_stages,   // Hold length in cycles
   input  logic      wr_full_raw,
   input  logic      wr_pfull_raw,
   input  logic      fifo_del_raw,
   output logic      full_stretch,
   output logic      pfull_stretch,
   output logic      del_stretch
);

   logic [2:0] raw;            // Bit 0 full, 1 pfull, 2 del
   logic [2:0] held;
   stretch_t   hold_cnt [3];   // One timer per flag

   assign raw = {fifo_del_raw, wr_pfull_raw, wr_full_raw};

   // Reload while raw is high, drain after it falls
   always_ff @(posedge rx_clock_fifo_sclk) begin
      if (!rx_reset_fifo_sclk_rst_n) begin
         for (int i = 0; i < 3; i++) begin
            hold_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 3; i++) begin
            if (raw[i]) begin
               hold_cnt[i] <= r_rx_stretch_num_stages;
            end else if (hold_cnt[i] != '0) begin
               hold_cnt[i] <= hold_cnt[i] - 1'b1;
            end
         end
      end
   end

   always_comb begin
      for (int i = 0; i < 3; i++) begin
         held[i] = raw[i] | (hold_cnt[i] != '0);   // No delay on rising edge
      end
   end

   assign full_stretch  = held[0];
   assign pfull_stretch = held[1];
   assign del_stretch   = held[2];

endmodule

`default_nettype wire

/* verilog/rx_word_align.sv */
// Receive word aligner
`default_nettype none

module rx_word_align import rx_dp_pkg::*; (
   input  logic      rx_clock_fifo_sclk,
   input  logic      rx_reset_fifo_sclk_rst_n,
   input  rx_word_t  aib_fabric_rx_data_in,   // Raw word from AIB
   output logic      wa_lock,                 // Aligned
   output logic      wa_word_ok,              // Current word fit to store
   output logic      wa_error,                // One cycle per bad marker
   output wa_cnt_t   wa_error_cnt             // Goes to status reg
);

   wa_state_t wa_state;
   wa_good_t  good_cnt;      // Toggles seen while searching
   wa_loss_t  loss_cnt;      // Consecutive bad markers while locked
   logic      ref_valid;     // First marker captured
   logic      prev_marker;   // Marker of last valid word
   logic      word_valid;
   logic      marker;
   logic      marker_ok;

   assign word_valid = aib_fabric_rx_data_in[VALID_BIT];
   assign marker     = aib_fabric_rx_data_in[MARKER_BIT];
   assign marker_ok  = (marker != prev_marker);   // Must flip every word

   // Lock taken from state, so the lock-making word is never stored
   assign wa_lock    = (wa_state == WA_LOCKED);
   assign wa_word_ok = word_valid & wa_lock & marker_ok;

   // ------------------------------
   // Lock / loss FSM
   // ------------------------------
   always_ff @(posedge rx_clock_fifo_sclk) begin
      if (!rx_reset_fifo_sclk_rst_n) begin
         wa_state     <= WA_SEARCH;
         good_cnt     <= '0;
         loss_cnt     <= '0;
         ref_valid    <= 1'b0;
         prev_marker  <= 1'b0;
         wa_error     <= 1'b0;
         wa_error_cnt <= '0;
      end else begin
         wa_error <= 1'b0;                        // Pulse only
         if (word_valid) begin
            prev_marker <= marker;                // Tracks every valid word
            case (wa_state)
               WA_SEARCH: begin
                  if (!ref_valid) begin
                     ref_valid <= 1'b1;           // Reference marker
                     good_cnt  <= '0;
                  end else if (!marker_ok) begin
                     good_cnt  <= '0;             // Start over
                  end else if (good_cnt == wa_good_t'(WA_LOCK_CNT - 1)) begin
                     wa_state  <= WA_LOCKED;
                     good_cnt  <= '0;
                     loss_cnt  <= '0;
                  end else begin
                     good_cnt  <= good_cnt + 1'b1;
                  end
               end
               WA_LOCKED: begin
                  if (marker_ok) begin
                     loss_cnt <= '0;
                  end else begin
                     wa_error <= 1'b1;
                     if (wa_error_cnt != '1) begin
                        wa_error_cnt <= wa_error_cnt + 1'b1;   // Saturate at 15
                     end
                     if (loss_cnt == wa_loss_t'(WA_LOSS_CNT - 1)) begin
                        wa_state  <= WA_SEARCH;   // Lock lost
                        ref_valid <= 1'b0;
                        loss_cnt  <= '0;
                     end else begin
                        loss_cnt  <= loss_cnt + 1'b1;
                     end
                  end
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/rx_dp_pkg.sv */
// Receive datapath shared definitions
`default_nettype none

package rx_dp_pkg;

   // ------------------------------
   // Widths and field positions
   // ------------------------------
   localparam int DWIDTH      = 40;   // AIB receive word
   localparam int AWIDTH      = 4;    // FIFO address bits
   localparam int FIFO_DEPTH  = 16;   // Entries, 2**AWIDTH
   localparam int MARKER_BIT  = 39;   // Alternating alignment marker
   localparam int VALID_BIT   = 38;   // Word strobe from AIB

   // Aligner limits
   localparam int WA_LOCK_CNT = 4;    // Good toggles to lock
   localparam int WA_LOSS_CNT = 2;    // Back to back bad markers to unlock

   // ------------------------------
   // Types
   // ------------------------------
   typedef logic [DWIDTH-1:0] rx_word_t;
   typedef logic [AWIDTH-1:0] fifo_addr_t;
   typedef logic [AWIDTH:0]   fifo_cnt_t;   // 0 to FIFO_DEPTH inclusive
   typedef logic [3:0]        wa_cnt_t;     // Error count, saturates at 15
   typedef logic [2:0]        stretch_t;    // Flag hold length

   // Aligner internal counters
   typedef logic [$clog2(WA_LOCK_CNT+1)-1:0] wa_good_t;
   typedef logic [$clog2(WA_LOSS_CNT+1)-1:0] wa_loss_t;

   // Aligner FSM
   typedef enum logic {
      WA_SEARCH = 1'b0,   // Hunting for marker toggles
      WA_LOCKED = 1'b1    // Aligned, words go to FIFO
   } wa_state_t;

   // Idle pattern sent on an empty read, valid bit clear
   localparam rx_word_t IDLE_WORD = 40'h00_0707_0707;

endpackage

`default_nettype wire
